/* verilog/audio_pkg.sv */
package audio_pkg;

    localparam int NCHAN       = 4;                 // audio channels
    localparam int CHAN_W      = 2;                 // channel index bits
    localparam int WORD_W      = 16;                // sample word / param data bits
    localparam int ADDR_W      = 16;                // DMA address bits
    localparam int SAMPLE_W    = 8;                 // signed sample bits
    localparam int VOL_W       = 7;                 // unsigned volume bits
    localparam int PERIOD_W    = 15;                // period reload bits (counter has +1 underflow bit)
    localparam int DAC_W       = 8;                 // DAC value bits
    localparam int MIX_SHIFT   = 6;                 // accumulator bits dropped before clamp
    localparam int ACC_W       = 16;                // mixer accumulator bits

    // register address is {chan, slot}
    localparam int REG_ADDR_W  = CHAN_W + 1;
    // param memory address is {work, chan, slot}
    localparam int PMEM_ADDR_W = CHAN_W + 2;

    // slot meaning depends on work bit: START/LENGTH when clear, PTRCNT/LENCNT when set
    typedef enum logic {
        SLOT_START_PTR  = 1'b0,
        SLOT_LENGTH_CNT = 1'b1
    } param_slot_e;

    typedef enum logic [2:0] {
        FS_CHECK,                                   // look for an empty channel
        FS_RD_PTR,                                  // queue PTRCNT read
        FS_DEC_LEN,                                 // LENCNT ready, write back decremented
        FS_RELOAD,                                  // queue START read
        FS_SET_LEN,                                 // LENGTH ready, copy into LENCNT
        FS_REQ,                                     // pointer ready, raise DMA request
        FS_WAIT_ACK                                 // hold request until acknowledge
    } fetch_state_e;

endpackage

/* verilog/audio_param_mem.sv */
`timescale 1ns/100ps

module audio_param_mem (
    input  wire logic                               clk,
    input  wire logic [audio_pkg::PMEM_ADDR_W-1:0]  rd_addr_i,
    output      logic [audio_pkg::WORD_W-1:0]       rd_data_o,
    input  wire logic                               wr_en_i,
    input  wire logic [audio_pkg::PMEM_ADDR_W-1:0]  wr_addr_i,
    input  wire logic [audio_pkg::WORD_W-1:0]       wr_data_i
);
    import audio_pkg::*;

    logic [WORD_W-1:0]  mem [2**PMEM_ADDR_W];           // START/LENGTH and PTRCNT/LENCNT per channel

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            mem[wr_addr_i] <= wr_data_i;
        end
        rd_data_o <= mem[rd_addr_i];                    // one cycle read latency, block RAM style
    end

endmodule

/* verilog/sample_fetch.sv */
`timescale 1ns/100ps

module sample_fetch (
    input  wire logic                               clk,
    input  wire logic                               reset_i,
    input  wire logic                               enable_i,
    input  wire logic                               reg_wr_i,
    input  wire logic [audio_pkg::REG_ADDR_W-1:0]   reg_addr_i,
    input  wire logic [audio_pkg::WORD_W-1:0]       reg_data_i,
    input  wire logic [audio_pkg::NCHAN-1:0]        word_empty_i,
    input  wire logic [audio_pkg::NCHAN-1:0]        restart_pend_i,
    output      logic [audio_pkg::PMEM_ADDR_W-1:0]  mem_rd_addr_o,
    input  wire logic [audio_pkg::WORD_W-1:0]       mem_rd_data_i,
    output      logic                               mem_wr_en_o,
    output      logic [audio_pkg::PMEM_ADDR_W-1:0]  mem_wr_addr_o,
    output      logic [audio_pkg::WORD_W-1:0]       mem_wr_data_o,
    output      logic                               dma_req_o,
    output      logic [audio_pkg::ADDR_W-1:0]       dma_addr_o,
    input  wire logic                               dma_ack_i,
    input  wire logic [audio_pkg::WORD_W-1:0]       dma_word_i,
    output      logic [audio_pkg::NCHAN-1:0]        word_load_o,
    output      logic [audio_pkg::WORD_W-1:0]       word_data_o
);
    import audio_pkg::*;

    fetch_state_e               state;                  // fetch FSM state
    logic [CHAN_W-1:0]          fetch_chan;             // channel being fetched
    logic                       fetch_reload;           // this fetch came from START
    logic                       found;                  // some buffer is empty
    logic [CHAN_W-1:0]          found_chan;             // lowest empty channel
    logic                       fetch_wr;               // FSM write strobe (registered)
    logic [PMEM_ADDR_W-1:0]     fetch_wr_addr;
    logic [WORD_W-1:0]          fetch_wr_data;
    logic                       reg_pend;               // held register write
    logic [REG_ADDR_W-1:0]      reg_pend_addr;
    logic [WORD_W-1:0]          reg_pend_data;

    function automatic logic [PMEM_ADDR_W-1:0] pmem_addr(input logic work,
            input logic [CHAN_W-1:0] chan, input param_slot_e slot);
        return {work, chan, slot};
    endfunction

    // lowest index wins
    always_comb begin
        found      = 1'b0;
        found_chan = '0;
        for (int i = NCHAN - 1; i >= 0; i--) begin
            if (word_empty_i[i]) begin
                found      = 1'b1;
                found_chan = CHAN_W'(i);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state         <= FS_CHECK;
            fetch_chan    <= '0;
            fetch_reload  <= 1'b0;
            fetch_wr      <= 1'b0;
            dma_req_o     <= 1'b0;
            mem_rd_addr_o <= '0;
        end else begin
            fetch_wr <= 1'b0;                                       // single cycle strobe
            case (state)
                FS_CHECK: begin
                    dma_req_o <= 1'b0;
                    if (found) begin
                        fetch_chan    <= found_chan;
                        mem_rd_addr_o <= pmem_addr(1'b1, found_chan, SLOT_LENGTH_CNT);
                        state         <= FS_RD_PTR;
                    end
                end
                FS_RD_PTR: begin
                    mem_rd_addr_o <= pmem_addr(1'b1, fetch_chan, SLOT_START_PTR);
                    state         <= FS_DEC_LEN;
                end
                FS_DEC_LEN: begin                                   // LENCNT on read port
                    fetch_wr      <= 1'b1;
                    fetch_wr_addr <= pmem_addr(1'b1, fetch_chan, SLOT_LENGTH_CNT);
                    fetch_wr_data <= mem_rd_data_i - 1'b1;
                    // zero count or restart, go back to START
                    if (mem_rd_data_i == '0 || restart_pend_i[fetch_chan]) begin
                        fetch_reload  <= 1'b1;
                        mem_rd_addr_o <= pmem_addr(1'b0, fetch_chan, SLOT_LENGTH_CNT);
                        state         <= FS_RELOAD;
                    end else begin
                        fetch_reload  <= 1'b0;
                        state         <= FS_REQ;                    // PTRCNT arrives next cycle
                    end
                end
                FS_RELOAD: begin                                    // PTRCNT data ignored
                    mem_rd_addr_o <= pmem_addr(1'b0, fetch_chan, SLOT_START_PTR);
                    state         <= FS_SET_LEN;
                end
                FS_SET_LEN: begin                                   // LENGTH on read port
                    fetch_wr      <= 1'b1;
                    fetch_wr_addr <= pmem_addr(1'b1, fetch_chan, SLOT_LENGTH_CNT);
                    fetch_wr_data <= mem_rd_data_i;
                    state         <= FS_REQ;
                end
                FS_REQ: begin                                       // PTRCNT or START ready
                    fetch_wr      <= 1'b1;
                    fetch_wr_addr <= pmem_addr(1'b1, fetch_chan, SLOT_START_PTR);
                    fetch_wr_data <= mem_rd_data_i + 1'b1;          // advance pointer
                    dma_req_o     <= 1'b1;
                    dma_addr_o    <= mem_rd_data_i;                 // held until ack
                    state         <= FS_WAIT_ACK;
                end
                FS_WAIT_ACK: begin
                    if (dma_ack_i) begin
                        dma_req_o <= 1'b0;
                        state     <= FS_CHECK;
                    end
                end
                default: state <= FS_CHECK;
            endcase

            if (!enable_i) begin
                state <= FS_CHECK;                                  // park while disabled
            end
        end
    end

    // a restart that arrives mid-fetch drops the stale word, channel stays empty
    always_comb begin
        word_load_o = '0;
        if (state == FS_WAIT_ACK && dma_ack_i &&
                !(restart_pend_i[fetch_chan] && !fetch_reload)) begin
            word_load_o[fetch_chan] = 1'b1;
        end
    end

    assign word_data_o = dma_word_i;

    // register writes queue behind FSM writes
    always_ff @(posedge clk) begin
        if (reset_i) begin
            reg_pend <= 1'b0;
        end else if (reg_wr_i) begin
            reg_pend <= 1'b1;
        end else if (!fetch_wr) begin
            reg_pend <= 1'b0;                                       // landed this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reg_wr_i) begin
            reg_pend_addr <= reg_addr_i;
            reg_pend_data <= reg_data_i;
        end
    end

    always_comb begin
        mem_wr_en_o   = fetch_wr | reg_pend;
        mem_wr_addr_o = fetch_wr ? fetch_wr_addr : {1'b0, reg_pend_addr};  // regs hit work=0
        mem_wr_data_o = fetch_wr ? fetch_wr_data : reg_pend_data;
    end

endmodule

/* verilog/audio_channel.sv */
`timescale 1ns/100ps

module audio_channel (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic                           enable_i,
    input  wire logic                           restart_i,
    input  wire logic [audio_pkg::PERIOD_W-1:0] period_i,
    input  wire logic                           word_load_i,
    input  wire logic [audio_pkg::WORD_W-1:0]   word_data_i,
    output      logic                           word_empty_o,
    output      logic                           restart_pend_o,
    output      logic [audio_pkg::SAMPLE_W-1:0] sample_o
);
    import audio_pkg::*;

    logic [WORD_W-1:0]      word_q;                     // buffered sample word
    logic                   word_valid;                 // buffer holds unplayed bytes
    logic                   odd_byte;                   // low byte next
    logic [PERIOD_W:0]      period_cnt;                 // top bit = underflow
    logic                   underflow;

    assign underflow    = period_cnt[PERIOD_W];
    assign word_empty_o = ~word_valid;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            word_valid     <= 1'b0;
            odd_byte       <= 1'b0;
            period_cnt     <= '1;                       // start underflowed
            restart_pend_o <= 1'b1;                     // first fetch loads START
            sample_o       <= '0;
        end else begin
            if (!underflow) begin
                period_cnt <= period_cnt - 1'b1;        // sticks once underflowed
            end
            if (underflow && word_valid) begin
                odd_byte   <= ~odd_byte;
                period_cnt <= {1'b0, period_i};
                sample_o   <= odd_byte ? word_q[SAMPLE_W-1:0] : word_q[WORD_W-1 -: SAMPLE_W];
                if (odd_byte) begin
                    word_valid <= 1'b0;                 // both bytes played
                end
            end
            if (word_load_i) begin
                word_valid     <= 1'b1;
                restart_pend_o <= 1'b0;
            end
            // restart / disable wins over load
            if (!enable_i || restart_i) begin
                restart_pend_o <= 1'b1;
                word_valid     <= 1'b0;
                odd_byte       <= 1'b0;                 // high byte first again
                period_cnt     <= '1;                   // force underflow
            end
        end
    end

    always_ff @(posedge clk) begin
        if (word_load_i) begin
            word_q <= word_data_i;
        end
    end

endmodule

/* verilog/audio_mixer.sv */
`timescale 1ns/100ps

module audio_mixer (
    input  wire logic                                       clk,
    input  wire logic                                       reset_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::SAMPLE_W-1:0] sample_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::VOL_W-1:0]    vol_l_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::VOL_W-1:0]    vol_r_i,
    output      logic [audio_pkg::DAC_W-1:0]                dac_l_o,
    output      logic [audio_pkg::DAC_W-1:0]                dac_r_o
);
    import audio_pkg::*;

    logic [CHAN_W:0]                mix_idx;            // NCHAN = output slot
    logic [CHAN_W-1:0]              chan;
    logic signed [SAMPLE_W-1:0]     samp_q;             // operands for this step
    logic signed [SAMPLE_W-1:0]     vol_l_q;
    logic signed [SAMPLE_W-1:0]     vol_r_q;
    logic signed [ACC_W-1:0]        acc_l;
    logic signed [ACC_W-1:0]        acc_r;
    logic signed [ACC_W-1:0]        sum_l;              // acc plus current product
    logic signed [ACC_W-1:0]        sum_r;

    // shift, clamp to signed byte range, then offset binary
    function automatic logic [DAC_W-1:0] clamp_u(input logic signed [ACC_W-1:0] sum);
        logic signed [ACC_W-MIX_SHIFT-1:0] v;
        v = (ACC_W-MIX_SHIFT)'(sum >>> MIX_SHIFT);
        if (v < -(2**(DAC_W-1))) begin
            return '0;
        end else if (v > 2**(DAC_W-1) - 1) begin
            return '1;
        end
        return v[DAC_W-1:0] ^ {1'b1, {(DAC_W-1){1'b0}}};
    endfunction

    assign chan  = mix_idx[CHAN_W-1:0];
    assign sum_l = acc_l + samp_q * vol_l_q;            // volume is zero-extended so always positive
    assign sum_r = acc_r + samp_q * vol_r_q;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mix_idx <= '0;
            acc_l   <= '0;
            acc_r   <= '0;
            dac_l_o <= '0;
            dac_r_o <= '0;
        end else if (mix_idx == NCHAN) begin
            dac_l_o <= clamp_u(sum_l);                  // last product folded in here
            dac_r_o <= clamp_u(sum_r);
            acc_l   <= '0;
            acc_r   <= '0;
            mix_idx <= '0;
        end else begin
            if (mix_idx != 0) begin                     // slot 0 holds stale operands
                acc_l <= sum_l;
                acc_r <= sum_r;
            end
            mix_idx <= mix_idx + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (mix_idx != NCHAN) begin
            samp_q  <= sample_i[chan*SAMPLE_W +: SAMPLE_W];
            vol_l_q <= {1'b0, vol_l_i[chan*VOL_W +: VOL_W]};
            vol_r_q <= {1'b0, vol_r_i[chan*VOL_W +: VOL_W]};
        end
    end

endmodule

/* verilog/pdm_dac.sv */
`timescale 1ns/100ps

module pdm_dac (
    input  wire logic                           clk,
    input  wire logic                           reset_i,
    input  wire logic [audio_pkg::DAC_W-1:0]    value_i,
    output      logic                           pulse_o
);
    import audio_pkg::*;

    logic [DAC_W-1:0]   acc;                    // sigma-delta error accumulator
    logic [DAC_W:0]     sum;                    // carry in top bit

    assign sum = {1'b0, acc} + {1'b0, value_i};

    always_ff @(posedge clk) begin
        if (reset_i) begin
            acc     <= '0;
            pulse_o <= 1'b0;
        end else begin
            acc     <= sum[DAC_W-1:0];
            pulse_o <= sum[DAC_W];
        end
    end

endmodule

/* verilog/audio_top.sv */
`timescale 1ns/100ps

module audio_top (
    input  wire logic                                           clk,
    input  wire logic                                           reset_i,
    input  wire logic                                           audio_enable_i,
    input  wire logic                                           reg_wr_i,
    input  wire logic [audio_pkg::REG_ADDR_W-1:0]               reg_addr_i,
    input  wire logic [audio_pkg::WORD_W-1:0]                   reg_data_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::VOL_W-1:0]   vol_l_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::VOL_W-1:0]   vol_r_i,
    input  wire logic [audio_pkg::NCHAN*audio_pkg::PERIOD_W-1:0] period_i,
    input  wire logic [audio_pkg::NCHAN-1:0]                    restart_i,
    output      logic                                           dma_req_o,
    output      logic [audio_pkg::ADDR_W-1:0]                   dma_addr_o,
    input  wire logic                                           dma_ack_i,
    input  wire logic [audio_pkg::WORD_W-1:0]                   dma_word_i,
    output      logic                                           pdm_l_o,
    output      logic                                           pdm_r_o
);
    import audio_pkg::*;

    logic [PMEM_ADDR_W-1:0]     mem_rd_addr;
    logic [WORD_W-1:0]          mem_rd_data;
    logic                       mem_wr_en;
    logic [PMEM_ADDR_W-1:0]     mem_wr_addr;
    logic [WORD_W-1:0]          mem_wr_data;
    logic [NCHAN-1:0]           word_empty;     // per channel buffer empty
    logic [NCHAN-1:0]           restart_pend;
    logic [NCHAN-1:0]           word_load;      // one-hot
    logic [WORD_W-1:0]          word_data;
    logic [NCHAN*SAMPLE_W-1:0]  sample;         // channel i in slice i
    logic [DAC_W-1:0]           dac_l;
    logic [DAC_W-1:0]           dac_r;

    audio_param_mem i_param_mem (
        .clk       (clk),
        .rd_addr_i (mem_rd_addr),
        .rd_data_o (mem_rd_data),
        .wr_en_i   (mem_wr_en),
        .wr_addr_i (mem_wr_addr),
        .wr_data_i (mem_wr_data)
    );

    sample_fetch i_fetch (
        .clk            (clk),
        .reset_i        (reset_i),
        .enable_i       (audio_enable_i),
        .reg_wr_i       (reg_wr_i),
        .reg_addr_i     (reg_addr_i),
        .reg_data_i     (reg_data_i),
        .word_empty_i   (word_empty),
        .restart_pend_i (restart_pend),
        .mem_rd_addr_o  (mem_rd_addr),
        .mem_rd_data_i  (mem_rd_data),
        .mem_wr_en_o    (mem_wr_en),
        .mem_wr_addr_o  (mem_wr_addr),
        .mem_wr_data_o  (mem_wr_data),
        .dma_req_o      (dma_req_o),
        .dma_addr_o     (dma_addr_o),
        .dma_ack_i      (dma_ack_i),
        .dma_word_i     (dma_word_i),
        .word_load_o    (word_load),
        .word_data_o    (word_data)
    );

    for (genvar i = 0; i < NCHAN; i++) begin : g_chan
        audio_channel i_chan (
            .clk            (clk),
            .reset_i        (reset_i),
            .enable_i       (audio_enable_i),
            .restart_i      (restart_i[i]),
            .period_i       (period_i[i*PERIOD_W +: PERIOD_W]),
            .word_load_i    (word_load[i]),
            .word_data_i    (word_data),
            .word_empty_o   (word_empty[i]),
            .restart_pend_o (restart_pend[i]),
            .sample_o       (sample[i*SAMPLE_W +: SAMPLE_W])
        );
    end

    audio_mixer i_mixer (
        .clk      (clk),
        .reset_i  (reset_i),
        .sample_i (sample),
        .vol_l_i  (vol_l_i),
        .vol_r_i  (vol_r_i),
        .dac_l_o  (dac_l),
        .dac_r_o  (dac_r)
    );

    pdm_dac i_dac_l (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_l),
        .pulse_o (pdm_l_o)
    );

    pdm_dac i_dac_r (
        .clk     (clk),
        .reset_i (reset_i),
        .value_i (dac_r),
        .pulse_o (pdm_r_o)
    );

endmodule

/* verification/tb_audio_top.sv */
`timescale 1ns/100ps

module tb_audio_top;
    import audio_pkg::*;

    localparam int HALF_PERIOD = 20;                        // 40 ns clock
    localparam int WAIT_LIMIT  = 3000;                      // cycles per wait loop
    localparam int LOOP_LEN    = 3;                         // LENGTH value, 4 words per loop
    localparam int ANY_CHAN    = NCHAN;                     // req_cnt slot for all channels

    logic                       clk = 1'b0;
    logic                       reset_i;
    logic                       audio_enable_i;
    logic                       reg_wr_i;
    logic [REG_ADDR_W-1:0]      reg_addr_i;
    logic [WORD_W-1:0]          reg_data_i;
    logic [NCHAN*VOL_W-1:0]     vol_l_i;
    logic [NCHAN*VOL_W-1:0]     vol_r_i;
    logic [NCHAN*PERIOD_W-1:0]  period_i;
    logic [NCHAN-1:0]           restart_i;
    logic                       dma_req_o;
    logic [ADDR_W-1:0]          dma_addr_o;
    logic                       dma_ack_i = 1'b0;
    logic [WORD_W-1:0]          dma_word_i = '0;
    logic                       pdm_l_o;
    logic                       pdm_r_o;

    integer             seed = 19850;                       // ack delay stream
    int                 errors = 0;
    int                 test_errors = 0;                    // errors before current test
    int                 tests_run = 0;
    int                 tests_failed = 0;
    int                 ack_delay = -1;                     // -1 = no request seen yet
    logic               fixed_en = 1'b0;                    // memory model returns fixed_word
    logic [WORD_W-1:0]  fixed_word = '0;
    logic               req_q = 1'b0;
    int                 req_cnt [NCHAN+1];                  // per channel, last = total
    int                 req_order [$];                      // channel of each request
    logic [ADDR_W-1:0]  last_addr [NCHAN];
    logic [ADDR_W-1:0]  start_mdl [NCHAN];                  // expected START/LENGTH/PTRCNT/LENCNT
    int                 len_mdl [NCHAN];
    logic [ADDR_W-1:0]  ptr_mdl [NCHAN];
    int                 cnt_mdl [NCHAN];
    logic               pend_mdl [NCHAN];                   // restart pending

    audio_top i_dut (.*);

    always #HALF_PERIOD clk = ~clk;

    // address must hold while the request waits
    assert property (@(posedge clk) disable iff (reset_i)
            (dma_req_o && !dma_ack_i) |=> $stable(dma_addr_o))
        else begin
            errors++;
            $display("dma_addr_o changed while dma_req_o was high at %0t ns", $time);
        end

    assert property (@(posedge clk) disable iff (reset_i)
            (dma_req_o && dma_ack_i) |=> !dma_req_o)
        else begin
            errors++;
            $display("dma_req_o stayed high after the acknowledge at %0t ns", $time);
        end

    task automatic compare_value(input string name, input int got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is 0x%0h, expected 0x%0h", $time, name, got, exp);
        end
    endtask

    task automatic compare_range(input string name, input int got, input int lo, input int hi);
        assert (got >= lo && got <= hi) else begin
            errors++;
            $display("Mismatch at %0t ns: %s is %0d, expected %0d to %0d",
                     $time, name, got, lo, hi);
        end
    endtask

    // expected pointer follows the reload rule: START on restart or zero count
    task automatic check_request(input logic [ADDR_W-1:0] addr);
        int                 c;
        logic [ADDR_W-1:0]  exp;
        c = addr[13:12];                                    // each channel owns a 4K range
        if (pend_mdl[c] || cnt_mdl[c] == 0) begin
            exp         = start_mdl[c];
            cnt_mdl[c]  = len_mdl[c];
            pend_mdl[c] = 1'b0;
        end else begin
            exp = ptr_mdl[c];
            cnt_mdl[c]--;
        end
        ptr_mdl[c] = exp + 1'b1;
        compare_value("dma_addr_o", addr, exp);
        req_cnt[c]++;
        req_cnt[ANY_CHAN]++;
        req_order.push_back(c);
        last_addr[c] = addr;
    endtask

    // request monitor
    always @(negedge clk) begin
        if (!reset_i && dma_req_o && !req_q) begin
            check_request(dma_addr_o);
        end
        req_q = dma_req_o;
    end

    // DMA memory model, random 0..7 cycle ack delay
    always @(negedge clk) begin
        dma_ack_i = 1'b0;
        if (!reset_i && dma_req_o) begin
            if (ack_delay < 0) begin
                ack_delay = {$random(seed)} % 8;
            end
            if (ack_delay == 0) begin
                dma_ack_i  = 1'b1;
                dma_word_i = fixed_en ? fixed_word : (dma_addr_o ^ 16'h5A5A);
                ack_delay  = -1;
            end else begin
                ack_delay--;
            end
        end else begin
            ack_delay = -1;
        end
    end

    task automatic write_reg(input int chan, input param_slot_e slot,
            input logic [WORD_W-1:0] data);
        @(negedge clk);
        reg_wr_i   = 1'b1;
        reg_addr_i = {chan[CHAN_W-1:0], slot};
        reg_data_i = data;
        if (slot == SLOT_START_PTR) begin
            start_mdl[chan] = data;
        end else begin
            len_mdl[chan] = data;
        end
        @(negedge clk);
        reg_wr_i = 1'b0;
        repeat (4) @(negedge clk);                          // room for a displaced write
    endtask

    task automatic pulse_restart(input int chan);
        @(negedge clk);
        restart_i[chan] = 1'b1;
        pend_mdl[chan]  = 1'b1;
        @(negedge clk);
        restart_i = '0;
    endtask

    task automatic await_requests(input int chan, input int n);
        int target;
        int cycles;
        target = req_cnt[chan] + n;
        cycles = 0;
        while (req_cnt[chan] < target && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            cycles++;
        end
        if (req_cnt[chan] < target) begin
            errors++;
            $display("Timeout at %0t ns: channel %0d did not make %0d requests in time",
                     $time, chan, n);
        end
    endtask

    // engine idle = no request for 20 cycles
    task automatic settle_engine();
        int quiet;
        int cycles;
        quiet  = 0;
        cycles = 0;
        while (quiet < 20 && cycles < WAIT_LIMIT) begin
            @(negedge clk);
            quiet = dma_req_o ? 0 : quiet + 1;
            cycles++;
        end
        if (quiet < 20) begin
            errors++;
            $display("Timeout at %0t ns: fetch engine never went idle", $time);
        end
    endtask

    task automatic count_highs(output int l, output int r);
        l = 0;
        r = 0;
        repeat (256) begin
            @(negedge clk);
            l += pdm_l_o;
            r += pdm_r_o;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_errors) begin
            $display("test %0d %s: passed", tests_run, name);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed with %0d errors", tests_run, name, errors - test_errors);
        end
        test_errors = errors;
    endtask

    initial begin
        int hi_l;
        int hi_r;
        int first;
        reset_i        = 1'b1;
        audio_enable_i = 1'b0;
        reg_wr_i       = 1'b0;
        reg_addr_i     = '0;
        reg_data_i     = '0;
        vol_l_i        = '0;
        vol_r_i        = '0;
        restart_i      = '0;
        period_i       = {NCHAN{15'h7FFF}};                 // other channels play slowly
        period_i[0 +: PERIOD_W] = 15'd2;                    // channel 0 loops fast
        for (int c = 0; c <= NCHAN; c++) begin
            req_cnt[c] = 0;
        end
        for (int c = 0; c < NCHAN; c++) begin
            pend_mdl[c]  = 1'b1;                            // reset leaves restart pending
            cnt_mdl[c]   = 0;
            ptr_mdl[c]   = '0;
            start_mdl[c] = '0;
            len_mdl[c]   = 0;
        end

        repeat (2) @(posedge clk);
        @(negedge clk);
        compare_value("dma_req_o", dma_req_o, 0);
        compare_value("pdm_l_o", pdm_l_o, 0);
        compare_value("pdm_r_o", pdm_r_o, 0);
        reset_i = 1'b0;
        for (int c = 0; c < NCHAN; c++) begin
            write_reg(c, SLOT_START_PTR, 16'(c * 'h1000 + 'h100));
            write_reg(c, SLOT_LENGTH_CNT, LOOP_LEN);
        end
        count_highs(hi_l, hi_r);
        compare_range("pdm_l_o highs", hi_l, 128, 129);     // zero volume sits at mid-scale
        compare_range("pdm_r_o highs", hi_r, 128, 129);
        compare_value("request count", req_cnt[ANY_CHAN], 0);
        finish_test("reset state");

        @(negedge clk);
        audio_enable_i = 1'b1;
        await_requests(0, 12);                              // three passes through the loop
        finish_test("looping address sequence");

        period_i[0 +: PERIOD_W] = 15'h7FFF;                 // park channel 0
        settle_engine();
        pulse_restart(0);
        await_requests(0, 1);
        compare_value("dma_addr_o", last_addr[0], start_mdl[0]);
        settle_engine();
        audio_enable_i = 1'b0;
        for (int c = 0; c < NCHAN; c++) begin
            pend_mdl[c] = 1'b1;                             // disable marks all restart pending
        end
        first = req_cnt[ANY_CHAN];
        repeat (100) @(negedge clk);
        compare_value("requests while disabled", req_cnt[ANY_CHAN], first);
        audio_enable_i = 1'b1;
        first = req_order.size();
        await_requests(ANY_CHAN, NCHAN);
        for (int c = 0; c < NCHAN; c++) begin
            compare_value("request channel", req_order[first + c], c);
        end
        finish_test("restart and disable");

        period_i[0 +: PERIOD_W] = 15'd2;
        pulse_restart(0);                                   // back to continuous fetches
        await_requests(0, 4);
        for (int k = 0; k < 4; k++) begin
            write_reg(1, SLOT_START_PTR, 16'(16'h1800 + 16 * k));
        end
        pulse_restart(1);
        await_requests(1, 1);
        compare_value("dma_addr_o", last_addr[1], 16'h1830);
        finish_test("register writes under load");

        fixed_word = 16'h4040;
        fixed_en   = 1'b1;
        vol_l_i[0 +: VOL_W] = 7'd64;
        await_requests(0, 3);
        repeat (16) @(negedge clk);
        count_highs(hi_l, hi_r);
        compare_range("pdm_l_o highs", hi_l, 192, 193);     // 64*64 >>> 6 = 64, offset 192
        compare_range("pdm_r_o highs", hi_r, 128, 129);
        finish_test("mixing nominal");

        vol_r_i[0 +: VOL_W]     = 7'd127;
        vol_r_i[VOL_W +: VOL_W] = 7'd127;
        fixed_word = 16'h7F7F;
        pulse_restart(1);                                   // channel 1 picks up the new word
        await_requests(1, 1);
        await_requests(0, 3);
        repeat (16) @(negedge clk);
        count_highs(hi_l, hi_r);
        compare_range("pdm_r_o highs", hi_r, 255, 256);     // clamps at +127, value 255
        fixed_word = 16'h8080;
        pulse_restart(1);
        await_requests(1, 1);
        await_requests(0, 3);
        repeat (16) @(negedge clk);
        count_highs(hi_l, hi_r);
        compare_range("pdm_r_o highs", hi_r, 0, 0);         // clamps at -128
        finish_test("mixing limits");

        $display("summary: %0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule

/* vlog.f */
verilog/audio_pkg.sv
verilog/audio_param_mem.sv
verilog/sample_fetch.sv
verilog/audio_channel.sv
verilog/audio_mixer.sv
verilog/pdm_dac.sv
verilog/audio_top.sv
verification/tb_audio_top.sv
